/* run.sh */
#!/bin/sh
# Build and run the front-end testbench with Verilator; verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module frontEndTb \
  -Mdir obj_dir -o frontEndSim > build.log 2>&1 \
  && ./obj_dir/frontEndSim > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
if grep -q "Simulation failed" sim.log; then
  echo "FAIL (see build.log and sim.log)"
  exit 1
fi
echo "PASS"

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic arstN
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for 5 cycles, released on a falling edge
  initial begin
    arstN = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arstN <= 1'b1;
  end

endmodule

/* sim/frontEndTb.sv */
`timescale 1ns/1ps

module frontEndTb;
  import cpuPkg::*;

  localparam int NUM_ENTRIES    = 20;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES;  // Per traced instruction
  localparam int HALT_WATCH     = 30;                // Quiet cycles expected after HLT

  // Control bits {aluSrc, zEn, nvEn, memEnable, memWrite, regWrite, memToReg, hlt, pcs}
  localparam logic [8:0] CTRL_ALU   = 9'b011001000;
  localparam logic [8:0] CTRL_SHIFT = 9'b110001000;
  localparam logic [8:0] CTRL_LW    = 9'b100101100;
  localparam logic [8:0] CTRL_SW    = 9'b100110000;
  localparam logic [8:0] CTRL_IMM8  = 9'b100001000;  // LLB and LHB
  localparam logic [8:0] CTRL_NONE  = 9'b000000000;  // B and BR
  localparam logic [8:0] CTRL_HLT   = 9'b000000010;

  logic   clk, arstN;
  logic   wbCyc, wbStb, wbAck, wbRegWrite;
  word_t  wbAdr, wbDatI, wbRegData;
  regId_t wbRegRd;
  flags_t flags;
  logic   idValid, aluSrc, zEn, nvEn, memEnable, memWrite, regWrite, memToReg;
  logic   hlt, pcs, halt;
  regId_t srcReg1, srcReg2, regRd;
  word_t  aluIn1, aluIn2, memWriteData;
  aluOp_t aluOp;

  //////////////////////////////////////////////////
  // Trace table and models
  //////////////////////////////////////////////////
  word_t      addrTbl [NUM_ENTRIES];  // Expected fetch address
  word_t      instTbl [NUM_ENTRIES];
  flags_t     flagTbl [NUM_ENTRIES];  // Flags shown while decoding
  regId_t     s1Tbl [NUM_ENTRIES];
  regId_t     s2Tbl [NUM_ENTRIES];
  word_t      immTbl [NUM_ENTRIES];   // aluIn2 when aluSrc is set
  aluOp_t     opTbl [NUM_ENTRIES];
  logic [8:0] ctrlTbl [NUM_ENTRIES];
  regId_t     wbRdTbl [NUM_ENTRIES];  // Same-cycle write-back register or 0 for none
  word_t      wbDataTbl [NUM_ENTRIES];

  word_t      mem [256];              // Instruction memory, word addressed
  word_t      model [NUM_REGS];       // Register model
  integer     seed;
  logic [1:0] waitCnt;                // Wait states left for this request
  logic       memReady, sawFirstReq;
  word_t      lastAckAdr;
  int         numLoaded, errors, cycles, idx;
  string      where;

  clockGen clkGen (.clk(clk), .arstN(arstN));

  frontEnd uut (
    .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
    .wbDatI(wbDatI), .wbAck(wbAck), .wbRegWrite(wbRegWrite), .wbRegRd(wbRegRd),
    .wbRegData(wbRegData), .flags(flags), .idValid(idValid), .srcReg1(srcReg1),
    .srcReg2(srcReg2), .regRd(regRd), .aluIn1(aluIn1), .aluIn2(aluIn2),
    .memWriteData(memWriteData), .aluOp(aluOp), .aluSrc(aluSrc), .zEn(zEn), .nvEn(nvEn),
    .memEnable(memEnable), .memWrite(memWrite), .regWrite(regWrite),
    .memToReg(memToReg), .hlt(hlt), .pcs(pcs), .halt(halt)
  );

  task automatic check(string what, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s %s got %h expected %h", $time, where, what, got, exp);
    end
  endtask

  task automatic addEntry(word_t addr, word_t inst, flags_t flg, regId_t s1, regId_t s2,
                          word_t imm, aluOp_t op, logic [8:0] ctrl, regId_t wbRd,
                          word_t wbData);
    addrTbl[numLoaded]   = addr;
    instTbl[numLoaded]   = inst;
    flagTbl[numLoaded]   = flg;
    s1Tbl[numLoaded]     = s1;
    s2Tbl[numLoaded]     = s2;
    immTbl[numLoaded]    = imm;
    opTbl[numLoaded]     = op;
    ctrlTbl[numLoaded]   = ctrl;
    wbRdTbl[numLoaded]   = wbRd;
    wbDataTbl[numLoaded] = wbData;
    mem[addr[8:1]]       = inst;  // Program lives at the traced address
    numLoaded++;
  endtask

  // Program in execution order with flags as {Z, V, N}
  task automatic loadTable();
    addEntry(16'h0000, 16'h0612, 3'b000, 4'd1, 4'd2, 16'h0000, ADD, CTRL_ALU, 4'd0, 16'h0);
    addEntry(16'h0002, 16'h1730, 3'b000, 4'd3, 4'd0, 16'h0000, SUB, CTRL_ALU, 4'd0, 16'h0);
    addEntry(16'h0004, 16'h2805, 3'b000, 4'd0, 4'd5, 16'h0000, XOR, CTRL_ALU, 4'd0, 16'h0);
    addEntry(16'h0006, 16'h4934, 3'b000, 4'd3, 4'd4, 16'h0004, SLL, CTRL_SHIFT, 4'd0, 16'h0);
    addEntry(16'h0008, 16'h595F, 3'b000, 4'd5, 4'hF, 16'h000F, SRA, CTRL_SHIFT, 4'd0, 16'h0);
    addEntry(16'h000A, 16'h8A1E, 3'b000, 4'd1, 4'hE, 16'hFFFE, ADD, CTRL_LW, 4'd0, 16'h0);
    addEntry(16'h000C, 16'h9327, 3'b000, 4'd2, 4'd3, 16'h0007, ADD, CTRL_SW, 4'd0, 16'h0);
    addEntry(16'h000E, 16'hA4A5, 3'b000, 4'd4, 4'd5, 16'h00A5, LLB, CTRL_IMM8, 4'd0, 16'h0);
    addEntry(16'h0010, 16'hB59C, 3'b000, 4'd5, 4'hC, 16'h009C, LHB, CTRL_IMM8, 4'd0, 16'h0);
    addEntry(16'h0012, 16'hC003, 3'b100, 4'd0, 4'd3, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h0014, 16'hC203, 3'b100, 4'd0, 4'd3, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h001C, 16'hC601, 3'b000, 4'd0, 4'd1, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h001E, 16'hC402, 3'b000, 4'd0, 4'd2, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h0024, 16'hCC1F, 3'b000, 4'd1, 4'hF, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h0026, 16'hCE10, 3'b000, 4'd1, 4'd0, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h0048, 16'hCBF8, 3'b001, 4'hF, 4'd8, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h003A, 16'hC801, 3'b100, 4'd0, 4'd1, 16'h0000, B, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h003E, 16'hDE40, 3'b000, 4'd4, 4'd0, 16'h0000, BR, CTRL_NONE, 4'd0, 16'h0);
    addEntry(16'h0040, 16'h0B13, 3'b000, 4'd1, 4'd3, 16'h0000, ADD, CTRL_ALU, 4'd1, 16'h7777);
    addEntry(16'h0042, 16'hF000, 3'b000, 4'd0, 4'd0, 16'h0000, HLT, CTRL_HLT, 4'd0, 16'h0);
  endtask

  //////////////////////////////////////////////////
  // Wishbone slave stepped on each falling edge
  //////////////////////////////////////////////////
  task automatic memoryStep();
    if (wbAck) begin
      wbAck   = 1'b0;                  // Master dropped cyc on the ack edge
      waitCnt = 2'($random(seed));     // 0 to 3 wait states for the next request
    end else if (wbCyc && wbStb) begin
      if (!sawFirstReq) begin
        check("first fetch address", wbAdr, RESET_PC);
        sawFirstReq = 1'b1;
      end
      if (memReady && waitCnt == 2'd0) begin
        wbAck      = 1'b1;
        wbDatI     = mem[wbAdr[8:1]];
        lastAckAdr = wbAdr;
      end else if (memReady) begin
        waitCnt--;
      end
    end
  endtask

  task automatic nextCycle();
    @(negedge clk);
    memoryStep();
  endtask

  task automatic writeBack(regId_t rd, word_t data);
    wbRegWrite = 1'b1;
    wbRegRd    = rd;
    wbRegData  = data;
    if (rd != '0) model[rd] = data;  // R0 keeps zero
    nextCycle();
  endtask

  task automatic checkEntry(int i);
    word_t expIn2;
    expIn2 = ctrlTbl[i][8] ? immTbl[i] : model[s2Tbl[i]];
    where  = $sformatf("entry %0d", i);
    check("fetch address", lastAckAdr, addrTbl[i]);
    check("srcReg1", 16'(srcReg1), 16'(s1Tbl[i]));
    check("srcReg2", 16'(srcReg2), 16'(s2Tbl[i]));
    check("regRd", 16'(regRd), 16'(instTbl[i][11:8]));
    check("aluIn1", aluIn1, model[s1Tbl[i]]);
    check("aluIn2", aluIn2, expIn2);
    check("memWriteData", memWriteData, model[s2Tbl[i]]);
    check("aluOp", 16'(aluOp), 16'(opTbl[i]));
    check("control", 16'({aluSrc, zEn, nvEn, memEnable, memWrite, regWrite, memToReg,
                          hlt, pcs}), 16'(ctrlTbl[i]));
    check("halt", 16'(halt), 16'(ctrlTbl[i][1]));
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: only %0d of %0d trace entries seen in %0d cycles",
             idx, NUM_ENTRIES, TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    seed        = 32'hbe7f7012;
    errors      = 0;
    idx         = 0;
    numLoaded   = 0;
    wbAck       = 1'b0;
    wbDatI      = '0;
    wbRegWrite  = 1'b0;
    wbRegRd     = '0;
    wbRegData   = '0;
    flags       = '0;
    memReady    = 1'b0;  // Slave stalls until registers are preloaded
    sawFirstReq = 1'b0;
    lastAckAdr  = '0;
    waitCnt     = 2'($random(seed));
    where       = "reset";
    for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = 16'h2000 | 16'(i);  // XOR filler
    loadTable();

    repeat (2) @(negedge clk);
    check("bus and valid", 16'({wbCyc, wbStb, idValid}), 16'h0);
    check("enables", 16'({regWrite, memEnable, memWrite, zEn, nvEn, pcs, hlt, halt}), 16'h0);
    while (!arstN) @(negedge clk);
    memoryStep();

    writeBack(4'd0, 16'hDEAD);  // R0 ignores writes
    writeBack(4'd1, 16'h0005);
    writeBack(4'd2, 16'hFFF3);
    writeBack(4'd3, 16'h1234);
    writeBack(4'd4, 16'h0040);  // BR target
    writeBack(4'd5, 16'h8001);
    wbRegWrite = 1'b0;
    flags      = flagTbl[0];
    memReady   = 1'b1;

    while (idx < NUM_ENTRIES) begin
      nextCycle();
      wbRegWrite = 1'b0;
      flags      = flagTbl[idx];  // Ready well before this entry decodes
      if (idValid) begin
        if (wbRdTbl[idx] != '0) begin
          // Write lands on the read of the same cycle
          wbRegWrite       = 1'b1;
          wbRegRd          = wbRdTbl[idx];
          wbRegData        = wbDataTbl[idx];
          model[wbRdTbl[idx]] = wbDataTbl[idx];
        end
        #1;
        checkEntry(idx);
        idx++;
      end
    end

    where = "after HLT";
    repeat (HALT_WATCH) begin
      nextCycle();
      wbRegWrite = 1'b0;
      check("idValid", 16'(idValid), 16'h0);
      check("wbCyc", 16'(wbCyc), 16'h0);
    end

    $display("Trace entries checked: %0d of %0d, errors: %0d", idx, NUM_ENTRIES, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim/frontEnd_props.sv */
`timescale 1ns/1ps

module frontEndProps (
  input logic                clk,
  input logic                arstN,
  input logic                wbCyc,
  input logic                wbStb,
  input logic                wbAck,
  input cpuPkg::word_t       wbAdr,
  input cpuPkg::fetchState_t state
);
  import cpuPkg::*;

  //////////////////////////////////////////////////
  // Wishbone classic master rules
  //////////////////////////////////////////////////
  stbInCyc: assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbCyc)
    else $error("wbStb high outside a bus cycle");

  // Address held until the slave acks
  adrStable: assert property (@(posedge clk) disable iff (!arstN)
                              wbStb && !wbAck |=> $stable(wbAdr))
    else $error("wbAdr changed during a pending request");

  // HALTED is final with no more bus traffic
  noCycHalted: assert property (@(posedge clk) disable iff (!arstN)
                                state == HALTED |-> !wbCyc)
    else $error("wbCyc high while fetch is halted");

endmodule

// Watches the fetch master
bind fetchUnit frontEndProps fetchProps (
  .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb),
  .wbAck(wbAck), .wbAdr(wbAdr), .state(state)
);

/* src/branchControl.sv */
`timescale 1ns/1ps

module branchControl (
  input  cpuPkg::cond_t                  cond,
  input  logic [cpuPkg::BRANCH_IMM_W-1:0] imm,     // Offset in halfwords
  input  cpuPkg::flags_t                 flags,
  input  cpuPkg::word_t                  rsData,  // BR target register
  input  cpuPkg::word_t                  pcNext,
  input  logic                           isBranch,
  input  logic                           isBr,
  output logic                           branchTaken,
  output cpuPkg::word_t                  branchTarget
);
  import cpuPkg::*;

  logic  z, v, n;
  logic  condMet;
  word_t offset;  // Sign-extended imm, times two

  assign z = flags[FLAG_Z];
  assign v = flags[FLAG_V];
  assign n = flags[FLAG_N];

  always_comb begin
    case (cond)
      NEQ:     condMet = !z;
      EQ:      condMet = z;
      GT:      condMet = !z && !n;
      LT:      condMet = n;
      GTE:     condMet = z || (!z && !n);
      LTE:     condMet = z || n;
      OVFL:    condMet = v;
      default: condMet = 1'b1;  // UNCOND
    endcase
  end

  assign offset = {{(15 - BRANCH_IMM_W){imm[BRANCH_IMM_W-1]}}, imm, 1'b0};

  // Only a branch opcode can be taken
  assign branchTaken = isBranch && condMet;

  // Non-branches fall through to pcNext
  assign branchTarget = !isBranch ? pcNext :
                        isBr      ? rsData :
                                    pcNext + offset;

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
  input  cpuPkg::opcode_t opcode,
  output logic            aluSrc,     // Immediate as second ALU operand
  output logic            memToReg,   // Write back memory data
  output logic            regWrite,
  output logic            regSrc,     // LLB/LHB, rd read as source 1
  output logic            memEnable,
  output logic            memWrite,
  output logic            isBranch,   // B or BR
  output logic            hlt,
  output logic            pcs,
  output logic            zEn,        // Update Z flag
  output logic            nvEn,       // Update N and V flags
  output cpuPkg::aluOp_t  aluOp
);
  import cpuPkg::*;

  always_comb begin
    // Defaults describe a no-op
    aluSrc    = 1'b0;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    regSrc    = 1'b0;
    memEnable = 1'b0;
    memWrite  = 1'b0;
    isBranch  = 1'b0;
    hlt       = 1'b0;
    pcs       = 1'b0;
    zEn       = 1'b0;
    nvEn      = 1'b0;
    aluOp     = opcode;  // ALU code tracks opcode for arith/logic

    case (opcode)
      ADD, SUB, XOR: begin
        regWrite = 1'b1;
        zEn      = 1'b1;
        nvEn     = 1'b1;  // Only these three touch N and V
      end
      RED: begin
        regWrite = 1'b1;
        zEn      = 1'b1;
      end
      SLL, SRA, ROR: begin  // Shift amount is imm4
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        zEn      = 1'b1;
      end
      PADDSB: regWrite = 1'b1;  // No flag update
      LW: begin
        aluSrc    = 1'b1;
        memToReg  = 1'b1;
        regWrite  = 1'b1;
        memEnable = 1'b1;
        aluOp     = ADD;  // Base plus offset
      end
      SW: begin
        aluSrc    = 1'b1;
        memEnable = 1'b1;
        memWrite  = 1'b1;
        aluOp     = ADD;
      end
      LLB, LHB: begin
        regSrc   = 1'b1;
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      B, BR: isBranch = 1'b1;
      PCS: begin
        regWrite = 1'b1;
        pcs      = 1'b1;
        aluOp    = ADD;
      end
      default: hlt = 1'b1;  // HLT
    endcase
  end

endmodule

/* src/cpuPkg.sv */
package cpuPkg;

  //////////////////////////////////////////////////
  // ISA widths and constants
  //////////////////////////////////////////////////
  localparam int NUM_REGS     = 16;  // Architectural register count
  localparam int BRANCH_IMM_W = 9;   // Branch offset field, in halfwords

  // Flag bit positions, Z on top
  localparam int FLAG_Z = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_N = 0;

  typedef logic [15:0] word_t;   // Data, instruction or address word
  typedef logic [3:0]  regId_t;  // Register number
  typedef logic [3:0]  aluOp_t;  // ALU operation select
  typedef logic [2:0]  flags_t;  // {Z, V, N}

  localparam word_t RESET_PC = 16'h0000;  // First fetch address

  //////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ADD    = 4'h0,
    SUB    = 4'h1,
    XOR    = 4'h2,
    RED    = 4'h3,
    SLL    = 4'h4,
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,
    LW     = 4'h8,
    SW     = 4'h9,
    LLB    = 4'hA,
    LHB    = 4'hB,
    B      = 4'hC,
    BR     = 4'hD,
    PCS    = 4'hE,
    HLT    = 4'hF
  } opcode_t;

  // Branch condition codes, bits [11:9] of B and BR
  typedef enum logic [2:0] {
    NEQ    = 3'd0,  // Z clear
    EQ     = 3'd1,  // Z set
    GT     = 3'd2,  // Z and N clear
    LT     = 3'd3,  // N set
    GTE    = 3'd4,
    LTE    = 3'd5,
    OVFL   = 3'd6,  // V set
    UNCOND = 3'd7
  } cond_t;

  // Fetch FSM states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    HALTED
  } fetchState_t;

endpackage

/* src/decode.sv */
`timescale 1ns/1ps

module decode (
  input  logic           clk,
  input  logic           arstN,
  input  logic           idValid,
  input  cpuPkg::word_t  idInst,
  input  cpuPkg::word_t  idPcNext,
  input  cpuPkg::flags_t flags,
  input  logic           wbRegWrite,   // Write-back port
  input  cpuPkg::regId_t wbRegRd,
  input  cpuPkg::word_t  wbRegData,
  output cpuPkg::regId_t srcReg1,
  output cpuPkg::regId_t srcReg2,
  output cpuPkg::regId_t regRd,
  output cpuPkg::word_t  aluIn1,
  output cpuPkg::word_t  aluIn2,
  output cpuPkg::word_t  memWriteData,
  output cpuPkg::aluOp_t aluOp,
  output logic           aluSrc,
  output logic           zEn,
  output logic           nvEn,
  output logic           memEnable,
  output logic           memWrite,
  output logic           regWrite,
  output logic           memToReg,
  output logic           hlt,
  output logic           pcs,
  output logic           redirect,     // Taken branch, predicted not taken
  output logic           halt,
  output cpuPkg::word_t  redirectPc
);
  import cpuPkg::*;

  opcode_t opcode;
  regId_t  rd, rs, rt;
  logic    regSrc, isBranch, branchTaken;
  logic    cuMemEnable, cuMemWrite, cuRegWrite, cuZEn, cuNvEn, cuHlt, cuPcs;
  word_t   srcData1, srcData2;
  word_t   immExt, aluImm;

  //////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////
  assign opcode = opcode_t'(idInst[15:12]);
  assign rd     = idInst[11:8];
  assign rs     = idInst[7:4];
  assign rt     = idInst[3:0];
  assign regRd  = rd;

  controlUnit uCtrl (
    .opcode(opcode), .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(cuRegWrite),
    .regSrc(regSrc), .memEnable(cuMemEnable), .memWrite(cuMemWrite), .isBranch(isBranch),
    .hlt(cuHlt), .pcs(cuPcs), .zEn(cuZEn), .nvEn(cuNvEn), .aluOp(aluOp)
  );

  // Source 1 is rd for LLB/LHB, source 2 is rd for SW
  assign srcReg1 = regSrc ? rd : rs;
  assign srcReg2 = cuMemWrite ? rd : rt;

  registerFile uRegs (
    .clk(clk), .arstN(arstN), .srcReg1(srcReg1), .srcReg2(srcReg2),
    .dstReg(wbRegRd), .writeReg(wbRegWrite), .dstData(wbRegData),
    .srcData1(srcData1), .srcData2(srcData2)
  );

  // Cond in [11:9], offset in [8:0]
  branchControl uBranch (
    .cond(cond_t'(idInst[11:9])), .imm(idInst[BRANCH_IMM_W-1:0]), .flags(flags),
    .rsData(srcData1), .pcNext(idPcNext), .isBranch(isBranch), .isBr(opcode == BR),
    .branchTaken(branchTaken), .branchTarget(redirectPc)
  );

  //////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////
  assign immExt = cuMemEnable ? {{12{idInst[3]}}, idInst[3:0]}  // LW/SW offset
                              : {12'h000, idInst[3:0]};
  assign aluImm       = regSrc ? {8'h00, idInst[7:0]} : immExt;
  assign aluIn1       = srcData1;
  assign aluIn2       = aluSrc ? aluImm : srcData2;
  assign memWriteData = srcData2;  // rd value for SW

  // Enables only count in a valid cycle
  assign regWrite  = idValid && cuRegWrite;
  assign memEnable = idValid && cuMemEnable;
  assign memWrite  = idValid && cuMemWrite;
  assign zEn       = idValid && cuZEn;
  assign nvEn      = idValid && cuNvEn;
  assign pcs       = idValid && cuPcs;
  assign hlt       = idValid && cuHlt;   // Travels on to write-back
  assign halt      = idValid && cuHlt;   // Stops fetch
  assign redirect  = idValid && branchTaken;

endmodule

/* src/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
  input  logic          clk,
  input  logic          arstN,
  output logic          wbCyc,
  output logic          wbStb,
  output cpuPkg::word_t wbAdr,
  input  cpuPkg::word_t wbDatI,
  input  logic          wbAck,
  input  logic          redirect,     // Mispredict from decode
  input  logic          halt,         // HLT seen in decode
  input  cpuPkg::word_t redirectPc,
  output logic          fetchValid,   // One pulse per accepted ack
  output cpuPkg::word_t fetchInst,
  output cpuPkg::word_t fetchPcNext
);
  import cpuPkg::*;

  fetchState_t state;
  word_t       pc;
  word_t       pendPc;    // Redirect target seen mid-cycle
  logic        dropPend;  // Data of cycle in flight is stale
  logic        haltPend;

  assign wbCyc       = (state == REQ);
  assign wbStb       = (state == REQ);  // Classic, single beat
  assign wbAdr       = pc;
  assign fetchInst   = wbDatI;  // Sampled by the buffer on the ack edge
  assign fetchPcNext = pc + 16'd2;
  assign fetchValid  = wbCyc && wbAck && !redirect && !halt && !dropPend && !haltPend;

  //////////////////////////////////////////////////
  // Fetch FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= IDLE;
      pc       <= RESET_PC;
      dropPend <= 1'b0;
      haltPend <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (halt) begin
            state <= HALTED;
          end else begin
            state <= REQ;                    // Next request
            if (redirect) pc <= redirectPc;
          end
        end
        REQ: begin
          if (wbAck) begin
            dropPend <= 1'b0;
            haltPend <= 1'b0;
            if (halt || haltPend) state <= HALTED;  // Data discarded
            else begin
              state <= IDLE;                        // cyc drops here
              if (redirect)      pc <= redirectPc;
              else if (dropPend) pc <= pendPc;
              else               pc <= fetchPcNext;
            end
          end else begin
            if (halt)     haltPend <= 1'b1;  // Finish cycle first
            if (redirect) dropPend <= 1'b1;
          end
        end
        default: state <= HALTED;  // Stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == REQ && !wbAck && redirect) pendPc <= redirectPc;
  end

endmodule

/* src/frontEnd.sv */
`timescale 1ns/1ps

module frontEnd (
  input  logic           clk,
  input  logic           arstN,
  output logic           wbCyc,        // Wishbone instruction master
  output logic           wbStb,
  output cpuPkg::word_t  wbAdr,
  input  cpuPkg::word_t  wbDatI,
  input  logic           wbAck,
  input  logic           wbRegWrite,   // Write-back from later stages
  input  cpuPkg::regId_t wbRegRd,
  input  cpuPkg::word_t  wbRegData,
  input  cpuPkg::flags_t flags,
  output logic           idValid,      // Qualifies every decode output
  output cpuPkg::regId_t srcReg1,
  output cpuPkg::regId_t srcReg2,
  output cpuPkg::regId_t regRd,
  output cpuPkg::word_t  aluIn1,
  output cpuPkg::word_t  aluIn2,
  output cpuPkg::word_t  memWriteData,
  output cpuPkg::aluOp_t aluOp,
  output logic           aluSrc,
  output logic           zEn,
  output logic           nvEn,
  output logic           memEnable,
  output logic           memWrite,
  output logic           regWrite,
  output logic           memToReg,
  output logic           hlt,
  output logic           pcs,
  output logic           halt
);
  import cpuPkg::*;

  logic  fetchValid, redirect;
  word_t fetchInst, fetchPcNext, idInst, idPcNext, redirectPc;

  fetchUnit uFetch (
    .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
    .wbDatI(wbDatI), .wbAck(wbAck), .redirect(redirect), .halt(halt),
    .redirectPc(redirectPc), .fetchValid(fetchValid), .fetchInst(fetchInst),
    .fetchPcNext(fetchPcNext)
  );

  // Mispredict flushes the entry on the same edge as the redirect
  ifIdBuffer uIfId (
    .clk(clk), .arstN(arstN), .load(fetchValid), .flush(redirect), .inst(fetchInst),
    .pcNext(fetchPcNext), .idValid(idValid), .idInst(idInst), .idPcNext(idPcNext)
  );

  decode uDecode (
    .clk(clk), .arstN(arstN), .idValid(idValid), .idInst(idInst), .idPcNext(idPcNext),
    .flags(flags), .wbRegWrite(wbRegWrite), .wbRegRd(wbRegRd), .wbRegData(wbRegData),
    .srcReg1(srcReg1), .srcReg2(srcReg2), .regRd(regRd), .aluIn1(aluIn1),
    .aluIn2(aluIn2), .memWriteData(memWriteData), .aluOp(aluOp), .aluSrc(aluSrc),
    .zEn(zEn), .nvEn(nvEn), .memEnable(memEnable), .memWrite(memWrite),
    .regWrite(regWrite), .memToReg(memToReg), .hlt(hlt), .pcs(pcs),
    .redirect(redirect), .halt(halt), .redirectPc(redirectPc)
  );

endmodule

/* src/ifIdBuffer.sv */
`timescale 1ns/1ps

module ifIdBuffer (
  input  logic          clk,
  input  logic          arstN,
  input  logic          load,      // fetchValid
  input  logic          flush,     // Mispredict kills the entry
  input  cpuPkg::word_t inst,
  input  cpuPkg::word_t pcNext,
  output logic          idValid,
  output cpuPkg::word_t idInst,
  output cpuPkg::word_t idPcNext
);

  // Valid lasts one cycle unless reloaded, flush has priority
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idValid <= 1'b0;
    end else begin
      idValid <= load && !flush;
    end
  end

  // Payload only, qualified by idValid
  always_ff @(posedge clk) begin
    if (load) begin
      idInst   <= inst;
      idPcNext <= pcNext;
    end
  end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
  input  logic           clk,
  input  logic           arstN,
  input  cpuPkg::regId_t srcReg1,
  input  cpuPkg::regId_t srcReg2,
  input  cpuPkg::regId_t dstReg,
  input  logic           writeReg,
  input  cpuPkg::word_t  dstData,
  output cpuPkg::word_t  srcData1,
  output cpuPkg::word_t  srcData2
);
  import cpuPkg::*;

  word_t regs [NUM_REGS];

  // R0 is never written, so it keeps its reset value
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (writeReg && dstReg != '0) begin
      regs[dstReg] <= dstData;
    end
  end

  // One read port with write-through
  function automatic word_t readPort(regId_t idx);
    if (idx == '0) return '0;                          // Hardwired zero
    if (writeReg && dstReg == idx) return dstData;     // Same-cycle write
    return regs[idx];
  endfunction

  assign srcData1 = readPort(srcReg1);
  assign srcData2 = readPort(srcReg2);

endmodule

/* verilog.f */
src/cpuPkg.sv
src/controlUnit.sv
src/branchControl.sv
src/registerFile.sv
src/fetchUnit.sv
src/ifIdBuffer.sv
src/decode.sv
src/frontEnd.sv
sim/clockGen.sv
sim/frontEnd_props.sv
sim/frontEndTb.sv
